// ==== logic/gfx_pkg.sv ====
// Shared widths, depth codes and frame geometry for the pixel store
// Frame is fixed at 64x64 pixels and sized for the 32 bpp worst case
package gfx_pkg;

  localparam int SCREEN_W     = 64;
  localparam int SCREEN_H     = 64;
  localparam int MEM_WORDS    = 2048;  // 64*64*4 bytes over 8 bytes per word
  localparam int READ_LATENCY = 2;     // Cycles from rd_i to rd_valid_o

  localparam int PIX_IDX_W   = $clog2(SCREEN_W * SCREEN_H);  // Linear pixel index
  localparam int BYTE_ADDR_W = $clog2(MEM_WORDS * 8);        // Frame byte address

  typedef logic [1:0]  depth_t;
  typedef logic [31:0] color_t;     // Right aligned colour value
  typedef logic [63:0] mem_word_t;
  typedef logic [7:0]  byte_sel_t;
  typedef logic [2:0]  lane_t;      // Byte offset inside a memory word
  typedef logic [5:0]  coord_t;
  typedef logic [10:0] word_addr_t;

  // Depth codes, 2'b10 is left unsupported
  localparam depth_t DEPTH_8  = 2'b00;
  localparam depth_t DEPTH_16 = 2'b01;
  localparam depth_t DEPTH_32 = 2'b11;

  // Colour bits kept for a depth, zero for the unsupported code
  function automatic color_t depth_mask(input depth_t depth);
    case (depth)
      DEPTH_8:  return 32'h0000_00ff;
      DEPTH_16: return 32'h0000_ffff;
      DEPTH_32: return 32'hffff_ffff;
      default:  return '0;
    endcase
  endfunction

  // Rounds a lane down to the natural alignment of the pixel size
  function automatic lane_t lane_align(input depth_t depth, input lane_t lane);
    case (depth)
      DEPTH_16: return lane & 3'b110;
      DEPTH_32: return lane & 3'b100;
      default:  return lane;  // 8 bpp sits on any lane
    endcase
  endfunction

endpackage

// ==== logic/pixel_bus_if.sv ====
// Word access from the pixel pipeline to the frame memory
// One access per cycle, we and re are never high together
`timescale 1ns/1ps

interface pixel_bus_if
  import gfx_pkg::*;
();

  logic       we;     // Write strobe, commits at the next edge
  logic       re;     // Read strobe, rdata valid one cycle later
  word_addr_t addr;
  mem_word_t  wdata;  // Colour already placed in its lanes
  byte_sel_t  sel;    // Byte enables for writes
  mem_word_t  rdata;

  // Pipeline side drives the request and takes the read word
  modport master (
    output we,
    output re,
    output addr,
    output wdata,
    output sel,
    input  rdata
  );

  // Memory side
  modport mem (
    input  we,
    input  re,
    input  addr,
    input  wdata,
    input  sel,
    output rdata
  );

endinterface

// ==== logic/pixel_addr_gen.sv ====
// Registers a pixel request and turns x, y, depth into word address and lane
// Payload is only captured on cycles with a strobe, depth 2'b10 is scaled as 8 bpp
`timescale 1ns/1ps

module pixel_addr_gen
  import gfx_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       wr_i,     // One cycle write strobe
  input  logic       rd_i,     // One cycle read strobe
  input  coord_t     x_i,
  input  coord_t     y_i,
  input  depth_t     depth_i,
  input  color_t     color_i,
  output word_addr_t addr_o,
  output lane_t      lane_o,
  output depth_t     depth_o,
  output color_t     color_o,
  output logic       wr_o,     // Write strobe one cycle late
  output logic       rd_o      // Read strobe one cycle late
);

  logic [PIX_IDX_W-1:0]   pix_idx;
  logic [BYTE_ADDR_W-1:0] byte_addr;

  // Linear pixel index in raster order
  assign pix_idx = PIX_IDX_W'(y_i) * PIX_IDX_W'(SCREEN_W) + PIX_IDX_W'(x_i);

  // Scale by bytes per pixel with a shift
  always_comb begin
    case (depth_i)
      DEPTH_16: byte_addr = BYTE_ADDR_W'(pix_idx) << 1;
      DEPTH_32: byte_addr = BYTE_ADDR_W'(pix_idx) << 2;
      default:  byte_addr = BYTE_ADDR_W'(pix_idx);  // 8 bpp and the unsupported code
    endcase
  end

  // Strobes are control state and come out of reset low
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_o <= 1'b0;
      rd_o <= 1'b0;
    end else begin
      wr_o <= wr_i;
      rd_o <= rd_i;
    end
  end

  // Request payload, held until the next strobe
  always_ff @(posedge clk_i) begin
    if (wr_i || rd_i) begin
      addr_o  <= byte_addr[BYTE_ADDR_W-1:3];  // Word of 8 bytes
      lane_o  <= byte_addr[2:0];
      depth_o <= depth_i;
      color_o <= color_i;
    end
  end

endmodule

// ==== logic/color_to_memory.sv ====
// Places a colour into its byte lanes of a 64-bit word and forms byte selects
// Purely combinational, the unsupported depth gives an all zero select
`timescale 1ns/1ps

module color_to_memory
  import gfx_pkg::*;
(
  input  depth_t    depth_i,
  input  color_t    color_i,
  input  lane_t     lane_i,    // Byte offset, rounded down here to the pixel alignment
  output mem_word_t mem_o,
  output byte_sel_t sel_o
);

  lane_t     lane_al;
  logic [5:0] shift_bits;
  color_t    color_m;
  byte_sel_t sel_base;

  // Misaligned lanes fall back to the start of the pixel
  assign lane_al = lane_align(depth_i, lane_i);

  // Lane to bit position
  assign shift_bits = {lane_al, 3'b000};

  // Upper bits of a narrow colour must not spill into neighbouring pixels
  assign color_m = color_i & depth_mask(depth_i);

  // One, two or four lanes starting at lane 0
  always_comb begin
    case (depth_i)
      DEPTH_8:  sel_base = 8'h01;
      DEPTH_16: sel_base = 8'h03;
      DEPTH_32: sel_base = 8'h0f;
      default:  sel_base = 8'h00;  // Nothing is written for 2'b10
    endcase
  end

  assign sel_o = sel_base << lane_al;               // Contiguous, naturally aligned
  assign mem_o = {32'd0, color_m} << shift_bits;     // Bytes outside sel_o are don't care

endmodule

// ==== logic/memory_to_color.sv ====
// Extracts a right aligned colour from a 64-bit read word
// The unsupported depth reads back as zero
`timescale 1ns/1ps

module memory_to_color
  import gfx_pkg::*;
(
  input  depth_t    depth_i,
  input  mem_word_t mem_i,
  input  lane_t     lane_i,   // Same lane that addressed the write
  output color_t    color_o
);

  lane_t      lane_al;
  logic [5:0] shift_bits;
  mem_word_t  mem_sh;

  // Alignment matches the packing side so a write and read meet on the same bytes
  assign lane_al    = lane_align(depth_i, lane_i);
  assign shift_bits = {lane_al, 3'b000};

  // Bring the addressed pixel down to bit 0
  assign mem_sh = mem_i >> shift_bits;

  // Drop the neighbouring pixels above the depth width
  assign color_o = mem_sh[31:0] & depth_mask(depth_i);

endmodule

// ==== logic/frame_mem.sv ====
// Frame buffer of MEM_WORDS 64-bit words with per-byte write enables
// Contents are not cleared by reset, read data appears one cycle after re
`timescale 1ns/1ps

module frame_mem
  import gfx_pkg::*;
(
  input  logic        clk_i,
  pixel_bus_if.mem    bus
);

  mem_word_t mem_q [MEM_WORDS];  // Storage array

  // Byte lane writes, only the selected bytes change
  always_ff @(posedge clk_i) begin
    if (bus.we) begin
      for (int b = 0; b < 8; b++) begin
        if (bus.sel[b]) begin
          mem_q[bus.addr][b*8 +: 8] <= bus.wdata[b*8 +: 8];
        end
      end
    end
  end

  // Registered read, holds its value between reads
  always_ff @(posedge clk_i) begin
    if (bus.re) begin
      bus.rdata <= mem_q[bus.addr];  // Write and read never share a cycle
    end
  end

endmodule

// ==== logic/pixel_store_top.sv ====
// Single pixel store of 8, 16 or 32 bpp over a 64-bit frame memory
// No handshake, wr_i and rd_i are one-cycle strobes and must not overlap
`timescale 1ns/1ps

module pixel_store_top
  import gfx_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_n_i,
  input  logic   wr_i,        // Write request strobe
  input  logic   rd_i,        // Read request strobe
  input  coord_t x_i,
  input  coord_t y_i,
  input  depth_t depth_i,
  input  color_t color_i,
  output logic   rd_valid_o,  // Pulses READ_LATENCY cycles after rd_i
  output color_t color_o      // Meaningful only with rd_valid_o
);

  word_addr_t st_addr;
  lane_t      st_lane;
  depth_t     st_depth;
  color_t     st_color;
  logic       st_wr;
  logic       st_rd;

  lane_t      rd_lane_q;   // Lane of the read whose data is on rdata
  depth_t     rd_depth_q;
  logic       rd_valid_q;

  pixel_bus_if bus ();

  // Cycle 0 to 1, request capture and address arithmetic
  pixel_addr_gen u_addr_gen (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .wr_i    (wr_i),
    .rd_i    (rd_i),
    .x_i     (x_i),
    .y_i     (y_i),
    .depth_i (depth_i),
    .color_i (color_i),
    .addr_o  (st_addr),
    .lane_o  (st_lane),
    .depth_o (st_depth),
    .color_o (st_color),
    .wr_o    (st_wr),
    .rd_o    (st_rd)
  );

  // Cycle 1, lane placement straight onto the memory bus
  color_to_memory u_pack (
    .depth_i (st_depth),
    .color_i (st_color),
    .lane_i  (st_lane),
    .mem_o   (bus.wdata),
    .sel_o   (bus.sel)
  );

  assign bus.we   = st_wr;
  assign bus.re   = st_rd;
  assign bus.addr = st_addr;

  // Memory commits writes and registers reads at the end of cycle 1
  frame_mem u_mem (
    .clk_i (clk_i),
    .bus   (bus.mem)
  );

  // Valid pulse follows the read into cycle 2
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= st_rd;
    end
  end

  // Lane and depth travel with the read data
  always_ff @(posedge clk_i) begin
    if (st_rd) begin
      rd_lane_q  <= st_lane;
      rd_depth_q <= st_depth;
    end
  end

  // Cycle 2, colour taken out of the read word
  memory_to_color u_unpack (
    .depth_i (rd_depth_q),
    .mem_i   (bus.rdata),
    .lane_i  (rd_lane_q),
    .color_o (color_o)
  );

  assign rd_valid_o = rd_valid_q;

endmodule

// ==== test/pixel_store_assert.sv ====
// Bound checks on the strobe rule, write select shapes and read valid timing
// Checks are idle while rst_n_i is low and accept an empty select for depth 2'b10
`timescale 1ns/1ps

module pixel_store_assert
  import gfx_pkg::*;
(
  input logic      clk_i,
  input logic      rst_n_i,
  input logic      wr_i,        // Top level write strobe
  input logic      rd_i,        // Top level read strobe
  input logic      mem_we_i,    // Registered write towards the memory
  input byte_sel_t mem_sel_i,   // Byte enables on the memory bus
  input logic      rd_valid_i   // Read valid pulse at the top level
);

  int fail_cnt;

  initial fail_cnt = 0;

  // The design has a single address stage, so one request per cycle
  a_strobe_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(wr_i && rd_i))
    else begin
      fail_cnt++;
      $error("Write and read strobes were high in the same cycle");
    end

  // One, two or four aligned lanes, or none for the unsupported depth
  a_sel_legal: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_we_i |-> (mem_sel_i inside {8'h00, 8'h01, 8'h02, 8'h04, 8'h08, 8'h10, 8'h20,
                                    8'h40, 8'h80, 8'h03, 8'h0c, 8'h30, 8'hc0,
                                    8'h0f, 8'hf0}))
    else begin
      fail_cnt++;
      $error("Write byte selects were not a legal contiguous pattern");
    end

  a_rd_timing: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rd_valid_i == $past(rd_i, READ_LATENCY))  // Valid exactly READ_LATENCY cycles late
    else begin
      fail_cnt++;
      $error("Read valid did not follow the read strobe by the read latency");
    end

endmodule

bind pixel_store_top pixel_store_assert u_assert (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .wr_i       (wr_i),
  .rd_i       (rd_i),
  .mem_we_i   (st_wr),
  .mem_sel_i  (bus.sel),
  .rd_valid_i (rd_valid_o)
);

// ==== test/tb_pixel_store.sv ====
// Random pixel traffic at all depths checked against a byte array model of the frame
// Inputs change 2 ns after the rising edge, results are sampled on the falling edge
`timescale 1ns/1ps

module tb_pixel_store
  import gfx_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int CLEAR_N    = SCREEN_W * SCREEN_H;  // One 32 bpp write per pixel
  localparam int ZERO_RD_N  = 64;
  localparam int RAND32_N   = 128;
  localparam int MIXED_N    = 256;
  localparam int B2B_N      = 128;
  localparam int BAD_N      = 32;
  localparam int TOTAL_STROBES = CLEAR_N + ZERO_RD_N + 2 * RAND32_N + 2 * MIXED_N
                                 + 3 * B2B_N + 3 * BAD_N;
  localparam int WATCHDOG_NS = TOTAL_STROBES * CLK_PERIOD * 2 + 10_000;

  logic   clk_i;
  logic   rst_n_i;
  logic   wr_i;
  logic   rd_i;
  coord_t x_i;
  coord_t y_i;
  depth_t depth_i;
  color_t color_i;
  logic   rd_valid_o;
  color_t color_o;

  logic [7:0] frame_model [MEM_WORDS * 8];  // Reference frame, one entry per byte
  color_t     exp_q [$];                    // Expected colours of reads in flight
  color_t     exp_val;
  int         reads_issued;
  int         valid_seen;
  logic       rd_d1;                        // rd_i seen one falling edge ago
  logic       rd_d2;

  pixel_store_top DUT (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .wr_i       (wr_i),
    .rd_i       (rd_i),
    .x_i        (x_i),
    .y_i        (y_i),
    .depth_i    (depth_i),
    .color_i    (color_i),
    .rd_valid_o (rd_valid_o),
    .color_o    (color_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic abort_run();
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic fail_plain(input string msg);
    $display("%s", msg);
    abort_run();
  endtask

  task automatic check_color(input color_t got, input color_t exp, input string name);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_valid_count(input int got, input int exp, input string name);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
      abort_run();
    end
  endtask

  function automatic int bytes_per_pixel(input depth_t d);
    case (d)
      DEPTH_8:  return 1;
      DEPTH_16: return 2;
      DEPTH_32: return 4;
      default:  return 0;  // Unsupported code touches no byte
    endcase
  endfunction

  // Raster index times pixel size, so every pixel lands on its natural alignment
  function automatic int pixel_byte_addr(input coord_t x, input coord_t y, input depth_t d);
    int idx;
    idx = int'(y) * SCREEN_W + int'(x);
    return idx * bytes_per_pixel(d);
  endfunction

  task automatic model_write(input coord_t x, input coord_t y, input depth_t d,
                             input color_t c);
    int base;
    base = pixel_byte_addr(x, y, d);
    for (int b = 0; b < bytes_per_pixel(d); b++) begin
      frame_model[base + b] = c[b*8 +: 8];  // Little endian byte order
    end
  endtask

  function automatic color_t model_read(input coord_t x, input coord_t y, input depth_t d);
    color_t res;
    int     base;
    res  = '0;
    base = pixel_byte_addr(x, y, d);
    for (int b = 0; b < bytes_per_pixel(d); b++) begin
      res[b*8 +: 8] = frame_model[base + b];
    end
    return res;
  endfunction

  function automatic depth_t depth_of(input int k);
    case (k % 3)
      0:       return DEPTH_8;
      1:       return DEPTH_16;
      default: return DEPTH_32;
    endcase
  endfunction

  // Pixel inside the 4-byte group grp, sub picks the smaller pixel within it
  task automatic pixel_in_group(input depth_t d, input int grp, input int sub,
                                output coord_t x, output coord_t y);
    int idx;
    case (d)
      DEPTH_16: idx = grp * 2 + sub % 2;
      DEPTH_32: idx = grp;
      default:  idx = grp * 4 + sub % 4;
    endcase
    x = coord_t'(idx % SCREEN_W);
    y = coord_t'(idx / SCREEN_W);
  endtask

  // One strobe cycle, the model follows in issue order like the DUT pipeline
  task automatic issue(input logic wr, input logic rd, input coord_t x, input coord_t y,
                       input depth_t d, input color_t c);
    @(posedge clk_i);
    #2;
    wr_i    = wr;
    rd_i    = rd;
    x_i     = x;
    y_i     = y;
    depth_i = d;
    color_i = c;
    if (wr) model_write(x, y, d, c);
    if (rd) begin
      exp_q.push_back(model_read(x, y, d));
      reads_issued++;
    end
  endtask

  task automatic gap();
    @(posedge clk_i);
    #2;
    wr_i = 1'b0;
    rd_i = 1'b0;
  endtask

  task automatic maybe_gap();
    if ($urandom % 2) gap();  // Random idle cycle between requests
  endtask

  task automatic drain();
    gap();
    while (exp_q.size() != 0) @(posedge clk_i);  // Each read retires on its valid pulse
    repeat (2) @(posedge clk_i);
  endtask

  // Results of cycle 2 are stable at the falling edge
  always @(negedge clk_i) begin
    if (DUT.u_assert.fail_cnt != 0) begin
      fail_plain("A bound assertion on the DUT failed");
    end
    if (rd_valid_o !== rd_d2) begin
      fail_plain("rd_valid_o did not pulse exactly 2 cycles after rd_i");
    end
    if (rd_valid_o === 1'b1) begin
      valid_seen++;
      if (exp_q.size() == 0) begin
        fail_plain("rd_valid_o pulsed with no read outstanding");
      end else begin
        exp_val = exp_q.pop_front();
        check_color(color_o, exp_val, "color_o");
      end
    end
    rd_d2 = rd_d1;
    rd_d1 = rd_i;
  end

  initial begin
    #(WATCHDOG_NS);
    fail_plain("Watchdog expired before all tests finished");
  end

  initial begin
    coord_t cx;
    coord_t cy;
    coord_t wx [RAND32_N];
    coord_t wy [RAND32_N];
    depth_t dw;
    depth_t dr;
    int     k;
    int     idx;

    void'($urandom(33));
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    wr_i         = 1'b0;
    rd_i         = 1'b0;
    x_i          = '0;
    y_i          = '0;
    depth_i      = DEPTH_8;
    color_i      = '0;
    reads_issued = 0;
    valid_seen   = 0;
    rd_d1        = 1'b0;
    rd_d2        = 1'b0;
    for (int i = 0; i < MEM_WORDS * 8; i++) frame_model[i] = 8'h00;
    repeat (5) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;

    // Clear the whole frame, then zero reads at all four depth codes
    for (int i = 0; i < CLEAR_N; i++) begin
      issue(1'b1, 1'b0, coord_t'(i % SCREEN_W), coord_t'(i / SCREEN_W), DEPTH_32, '0);
    end
    for (int i = 0; i < ZERO_RD_N; i++) begin
      issue(1'b0, 1'b1, coord_t'($urandom), coord_t'($urandom), depth_t'(i % 4), '0);
      maybe_gap();
    end
    drain();

    // 32 bpp writes then reads of the same pixels
    for (int i = 0; i < RAND32_N; i++) begin
      wx[i] = coord_t'($urandom);
      wy[i] = coord_t'($urandom);
      issue(1'b1, 1'b0, wx[i], wy[i], DEPTH_32, $urandom);
      maybe_gap();
    end
    for (int i = 0; i < RAND32_N; i++) begin
      issue(1'b0, 1'b1, wx[i], wy[i], DEPTH_32, '0);
      maybe_gap();
    end
    drain();

    // Overlapping writes in a small pool of groups, read back at another depth
    for (int i = 0; i < MIXED_N; i++) begin
      k  = $urandom % 3;
      dw = depth_of(k);
      dr = depth_of(k + 1 + $urandom % 2);
      pixel_in_group(dw, $urandom % 32, $urandom % 4, cx, cy);
      issue(1'b1, 1'b0, cx, cy, dw, $urandom);
      maybe_gap();
      pixel_in_group(dr, $urandom % 32, $urandom % 4, cx, cy);
      issue(1'b0, 1'b1, cx, cy, dr, '0);
      maybe_gap();
    end
    drain();

    // Write, read of the same pixel and a random read on consecutive cycles
    for (int i = 0; i < B2B_N; i++) begin
      dw = depth_of($urandom % 3);
      cx = coord_t'($urandom);
      cy = coord_t'($urandom);
      issue(1'b1, 1'b0, cx, cy, dw, $urandom);
      issue(1'b0, 1'b1, cx, cy, dw, '0);
      issue(1'b0, 1'b1, coord_t'($urandom), coord_t'($urandom), depth_of($urandom % 3), '0);
    end
    drain();

    // Unsupported depth writes nothing and reads zero
    for (int i = 0; i < BAD_N; i++) begin
      cx  = coord_t'($urandom);
      cy  = coord_t'($urandom);
      idx = (int'(cy) * SCREEN_W + int'(cx)) / 4;  // 32 bpp pixel holding that byte
      issue(1'b1, 1'b0, cx, cy, 2'b10, $urandom);
      issue(1'b0, 1'b1, cx, cy, 2'b10, '0);
      issue(1'b0, 1'b1, coord_t'(idx % SCREEN_W), coord_t'(idx / SCREEN_W), DEPTH_32, '0);
      maybe_gap();
    end
    drain();

    check_valid_count(valid_seen, reads_issued, "rd_valid_o pulse count");
    if (DUT.u_assert.fail_cnt == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      fail_plain("A bound assertion on the DUT failed");
    end
  end

endmodule

// ==== all.f ====
logic/gfx_pkg.sv
logic/pixel_bus_if.sv
logic/pixel_addr_gen.sv
logic/color_to_memory.sv
logic/memory_to_color.sv
logic/frame_mem.sv
logic/pixel_store_top.sv
test/pixel_store_assert.sv
test/tb_pixel_store.sv

// ==== Bender.yml ====
package:
  name: pixel_store

sources:
  - logic/gfx_pkg.sv
  - logic/pixel_bus_if.sv
  - logic/pixel_addr_gen.sv
  - logic/color_to_memory.sv
  - logic/memory_to_color.sv
  - logic/frame_mem.sv
  - logic/pixel_store_top.sv
  - target: test
    files:
      - test/pixel_store_assert.sv
      - test/tb_pixel_store.sv
